/* source/wb_pkg.sv */
package wb_pkg;

   // bus widths.
   localparam int ADR_W = 32;
   localparam int DAT_W = 32;
   localparam int SEL_W = 4;

   // byte lanes per data word.
   localparam int LANE_W = DAT_W / SEL_W;

   typedef logic [ADR_W-1:0] adr_t;
   typedef logic [DAT_W-1:0] dat_t;
   typedef logic [SEL_W-1:0] sel_t;

endpackage

/* source/map_pkg.sv */
package map_pkg;

   // two address bits above BASE pick the target.
   typedef logic [1:0] tgt_t;

   localparam tgt_t TGT_RAM0 = 2'd0;
   localparam tgt_t TGT_RAM1 = 2'd1;
   localparam tgt_t TGT_REGS = 2'd2;
   localparam tgt_t TGT_NONE = 2'd3;  // no slave, decoder answers.

   // word offsets inside the register block.
   localparam logic [1:0] REG_ID      = 2'd0;
   localparam logic [1:0] REG_SCRATCH = 2'd1;
   localparam logic [1:0] REG_WRCNT   = 2'd2;

   localparam wb_pkg::dat_t REGS_ID       = 32'h5742_4d31;
   localparam wb_pkg::dat_t UNMAPPED_DATA = 32'hbad0_cafe;

endpackage

/* source/if_wb.sv */
interface if_wb;
   import wb_pkg::*;

   logic cyc;
   logic stb;
   logic we;
   adr_t adr;
   sel_t sel;
   dat_t dat_m;  // master to slave.
   dat_t dat_s;  // slave to master.
   logic ack;
   logic stall;

   modport master
     (output cyc, stb, we, adr, sel, dat_m,
      input  dat_s, ack, stall);

   modport slave
     (input  cyc, stb, we, adr, sel, dat_m,
      output dat_s, ack, stall);

endinterface

/* source/wb_decoder.sv */
module wb_decoder #(
   parameter int BASE = 28
) (
   input logic  clk_i,
   input logic  rst_i,
   if_wb.slave  mbus,
   if_wb.master p_ram0,
   if_wb.master p_ram1,
   if_wb.master p_regs
);
   import map_pkg::*;

   typedef enum logic {ST_IDLE, ST_LOCKED} state_t;

   state_t     state;
   state_t     state_next;
   tgt_t       active;
   tgt_t       active_next;
   tgt_t       tgt;
   logic [1:0] un_pend;
   logic       un_acc;
   logic       un_ack;

   // all but stb goes to every target.
   always_comb
   begin
      p_ram0.cyc   = mbus.cyc;
      p_ram1.cyc   = mbus.cyc;
      p_regs.cyc   = mbus.cyc;
      p_ram0.we    = mbus.we;
      p_ram1.we    = mbus.we;
      p_regs.we    = mbus.we;
      p_ram0.adr   = mbus.adr;
      p_ram1.adr   = mbus.adr;
      p_regs.adr   = mbus.adr;
      p_ram0.sel   = mbus.sel;
      p_ram1.sel   = mbus.sel;
      p_regs.sel   = mbus.sel;
      p_ram0.dat_m = mbus.dat_m;
      p_ram1.dat_m = mbus.dat_m;
      p_regs.dat_m = mbus.dat_m;
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state  <= ST_IDLE;
         active <= TGT_RAM0;
      end
      else
      begin
         state  <= state_next;
         active <= active_next;
      end
   end

   // lock onto the first target of a bus cycle.
   always_comb
   begin
      state_next  = state;
      active_next = active;
      case (state)
         ST_IDLE:
            if (mbus.cyc)
            begin
               state_next  = ST_LOCKED;
               active_next = mbus.adr[BASE+1:BASE];
            end
         ST_LOCKED:
            if (!mbus.cyc)
               state_next = ST_IDLE;
         default:
            state_next = ST_IDLE;
      endcase
   end

   assign tgt = (state == ST_LOCKED) ? active : mbus.adr[BASE+1:BASE];

   // unmapped region never stalls.
   assign un_acc = mbus.cyc && mbus.stb && (tgt == TGT_NONE);
   assign un_ack = (un_pend != 2'd0);

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         un_pend <= 2'd0;
      else if (!mbus.cyc)
         un_pend <= 2'd0;  // cycle over, drop leftovers.
      else if (un_acc && !un_ack)
         un_pend <= un_pend + 2'd1;
      else if (!un_acc && un_ack)
         un_pend <= un_pend - 2'd1;
   end

   always_comb
   begin
      p_ram0.stb = 1'b0;
      p_ram1.stb = 1'b0;
      p_regs.stb = 1'b0;
      mbus.dat_s = '0;
      mbus.ack   = 1'b0;
      mbus.stall = 1'b0;
      case (tgt)
         TGT_RAM0:
         begin
            p_ram0.stb = mbus.stb;
            mbus.dat_s = p_ram0.dat_s;
            mbus.ack   = p_ram0.ack;
            mbus.stall = p_ram0.stall;
         end
         TGT_RAM1:
         begin
            p_ram1.stb = mbus.stb;
            mbus.dat_s = p_ram1.dat_s;
            mbus.ack   = p_ram1.ack;
            mbus.stall = p_ram1.stall;
         end
         TGT_REGS:
         begin
            p_regs.stb = mbus.stb;
            mbus.dat_s = p_regs.dat_s;
            mbus.ack   = p_regs.ack;
            mbus.stall = p_regs.stall;
         end
         TGT_NONE:
         begin
            mbus.dat_s = UNMAPPED_DATA;
            mbus.ack   = un_ack;
         end
      endcase
   end

endmodule

/* source/wb_ram.sv */
module wb_ram #(
   parameter int RAM_AW = 6,
   parameter int WAIT   = 0
) (
   input logic clk_i,
   input logic rst_i,
   if_wb.slave bus
);
   import wb_pkg::*;

   localparam int CW = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

   typedef logic [RAM_AW-1:0] word_adr_t;

   dat_t          mem [2**RAM_AW];
   word_adr_t     idx;
   logic          acc;
   logic          busy;
   logic [CW-1:0] wcnt;
   logic          ack_q;
   dat_t          dat_q;

   assign idx  = bus.adr[RAM_AW+1:2];  // word index above byte offset.
   assign busy = (wcnt != '0);
   assign acc  = bus.cyc && bus.stb && !busy;

   assign bus.stall = busy;
   assign bus.ack   = ack_q;
   assign bus.dat_s = dat_q;

   // wait counter, loaded on each accepted strobe.
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wcnt  <= '0;
         ack_q <= 1'b0;
      end
      else
      begin
         if (acc)
            wcnt <= CW'(WAIT);
         else if (busy)
            wcnt <= wcnt - 1'b1;

         if (WAIT == 0)
            ack_q <= acc;  // fully pipelined.
         else
            ack_q <= (wcnt == CW'(1));
      end
   end

   // byte writes under sel.
   always_ff @(posedge clk_i)
   begin
      if (acc)
      begin
         if (bus.we)
         begin
            for (int i = 0; i < SEL_W; i++)
               if (bus.sel[i])
                  mem[idx][LANE_W*i +: LANE_W] <= bus.dat_m[LANE_W*i +: LANE_W];
            dat_q <= '0;
         end
         else
         begin
            dat_q <= mem[idx];  // held until the ack.
         end
      end
   end

endmodule

/* source/wb_regs.sv */
module wb_regs (
   input logic clk_i,
   input logic rst_i,
   if_wb.slave bus
);
   import wb_pkg::*;
   import map_pkg::*;

   logic [1:0] ofs;
   logic       acc;
   dat_t       scratch;
   dat_t       wrcnt;
   dat_t       rd_data;
   logic       ack_q;
   dat_t       dat_q;

   assign ofs = bus.adr[3:2];
   assign acc = bus.cyc && bus.stb;  // never stalls.

   assign bus.stall = 1'b0;
   assign bus.ack   = ack_q;
   assign bus.dat_s = dat_q;

   always_comb
   begin
      case (ofs)
         REG_ID:      rd_data = REGS_ID;
         REG_SCRATCH: rd_data = scratch;
         REG_WRCNT:   rd_data = wrcnt;
         default:     rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         scratch <= '0;
         wrcnt   <= '0;
         ack_q   <= 1'b0;
      end
      else
      begin
         ack_q <= acc;
         // only scratch takes writes.
         if (acc && bus.we && (ofs == REG_SCRATCH))
         begin
            for (int i = 0; i < SEL_W; i++)
               if (bus.sel[i])
                  scratch[LANE_W*i +: LANE_W] <= bus.dat_m[LANE_W*i +: LANE_W];
            wrcnt <= wrcnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (acc)
         dat_q <= bus.we ? dat_t'(0) : rd_data;
   end

endmodule

/* source/wb_fabric.sv */
module wb_fabric #(
   parameter int BASE   = 28,
   parameter int RAM_AW = 6
) (
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         cyc_i,
   input  logic         stb_i,
   input  logic         we_i,
   input  wb_pkg::adr_t adr_i,
   input  wb_pkg::sel_t sel_i,
   input  wb_pkg::dat_t dat_i,
   output wb_pkg::dat_t dat_o,
   output logic         ack_o,
   output logic         stall_o
);

   if_wb mbus ();
   if_wb b_ram0 ();
   if_wb b_ram1 ();
   if_wb b_regs ();

   // external master onto the internal bus.
   assign mbus.cyc   = cyc_i;
   assign mbus.stb   = stb_i;
   assign mbus.we    = we_i;
   assign mbus.adr   = adr_i;
   assign mbus.sel   = sel_i;
   assign mbus.dat_m = dat_i;

   assign dat_o   = mbus.dat_s;
   assign ack_o   = mbus.ack;
   assign stall_o = mbus.stall;

   wb_decoder #(
      .BASE (BASE)
   ) dec0 (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .mbus   (mbus.slave),
      .p_ram0 (b_ram0.master),
      .p_ram1 (b_ram1.master),
      .p_regs (b_regs.master)
   );

   // zero wait.
   wb_ram #(
      .RAM_AW (RAM_AW),
      .WAIT   (0)
   ) ram0 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .bus   (b_ram0.slave)
   );

   // two wait states, one transfer at a time.
   wb_ram #(
      .RAM_AW (RAM_AW),
      .WAIT   (2)
   ) ram1 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .bus   (b_ram1.slave)
   );

   wb_regs regs0 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .bus   (b_regs.slave)
   );

endmodule

/* verification/tb_fabric.sv */
module tb_fabric;
   timeunit 1ns;
   timeprecision 1ps;
   import wb_pkg::*;
   import map_pkg::*;

   localparam int BASE      = 28;
   localparam int RAM_AW    = 6;
   localparam int RAM_WORDS = 1 << RAM_AW;
   localparam int RAM1_WAIT = 2;
   localparam int N_SINGLE  = 40;
   localparam int N_BURST   = 20;
   localparam int MAX_XFERS = 2 * RAM_WORDS + 2 * N_SINGLE + 5 * N_BURST * 6;
   // three cycles of ram1, plus gap and bus cycle turnaround.
   localparam int WD_TIME   = MAX_XFERS * (3 + 3) * 8 + 2000;

   logic clk_i = 1'b0;
   logic rst_i;
   logic cyc_i;
   logic stb_i;
   logic we_i;
   adr_t adr_i;
   sel_t sel_i;
   dat_t dat_i;
   dat_t dat_o;
   logic ack_o;
   logic stall_o;

   int   seed;
   int   err_data = 0;
   int   err_proto = 0;
   dat_t m_ram0 [RAM_WORDS];
   dat_t m_ram1 [RAM_WORDS];
   dat_t m_scratch = '0;
   dat_t m_wrcnt = '0;
   int   m_wait1 = 0;  // ram1 stall cycles left.
   dat_t exp_q [$];   // expected dat_o, one per accepted strobe.
   logic locked = 1'b0;
   logic cyc_q = 1'b0;
   tgt_t lk_tgt;
   logic q_we [$];
   adr_t q_adr [$];
   sel_t q_sel [$];
   dat_t q_dat [$];

   wb_fabric #(
      .BASE   (BASE),
      .RAM_AW (RAM_AW)
   ) dut0 (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .cyc_i   (cyc_i),
      .stb_i   (stb_i),
      .we_i    (we_i),
      .adr_i   (adr_i),
      .sel_i   (sel_i),
      .dat_i   (dat_i),
      .dat_o   (dat_o),
      .ack_o   (ack_o),
      .stall_o (stall_o)
   );

   always #4 clk_i = ~clk_i;

   function automatic dat_t merge(input dat_t old, input dat_t nw, input sel_t sel);
      dat_t r;
      r = old;
      for (int i = 0; i < SEL_W; i++)
         if (sel[i])
            r[8*i +: 8] = nw[8*i +: 8];
      return r;
   endfunction

   // reference model, one accepted transfer. returns the data the ack carries.
   function automatic dat_t model_access(input tgt_t t, input logic we, input adr_t adr,
                                         input sel_t sel, input dat_t dat);
      dat_t r;
      r = '0;
      case (t)
         TGT_RAM0:
            if (we)
               m_ram0[adr[RAM_AW+1:2]] = merge(m_ram0[adr[RAM_AW+1:2]], dat, sel);
            else
               r = m_ram0[adr[RAM_AW+1:2]];
         TGT_RAM1:
            if (we)
               m_ram1[adr[RAM_AW+1:2]] = merge(m_ram1[adr[RAM_AW+1:2]], dat, sel);
            else
               r = m_ram1[adr[RAM_AW+1:2]];
         TGT_REGS:
            if (we)
            begin
               if (adr[3:2] == REG_SCRATCH)
               begin
                  m_scratch = merge(m_scratch, dat, sel);
                  m_wrcnt   = m_wrcnt + 32'd1;
               end
            end
            else if (adr[3:2] == REG_ID)
               r = REGS_ID;
            else if (adr[3:2] == REG_SCRATCH)
               r = m_scratch;
            else if (adr[3:2] == REG_WRCNT)
               r = m_wrcnt;
         default:
            r = UNMAPPED_DATA;  // reads and writes alike.
      endcase
      return r;
   endfunction

   function automatic int burst_len();
      return 2 + int'($unsigned($random(seed)) % 5);
   endfunction

   task automatic push_xfer(input logic we, input adr_t adr, input sel_t sel, input dat_t dat);
      q_we.push_back(we);
      q_adr.push_back(adr);
      q_sel.push_back(sel);
      q_dat.push_back(dat);
   endtask

   task automatic put_xfer(input int i);
      stb_i <= 1'b1;
      we_i  <= q_we[i];
      adr_i <= q_adr[i];
      sel_i <= q_sel[i];
      dat_i <= q_dat[i];
   endtask

   // one bus cycle over the queued transfers, held until every ack is in.
   task automatic run_cycle();
      int   n;
      int   sent;
      int   acks;
      logic accepted;
      n    = q_adr.size();
      sent = 0;
      acks = 0;
      @(posedge clk_i);
      cyc_i <= 1'b1;
      put_xfer(0);
      while (acks < n)
      begin
         @(posedge clk_i);
         accepted = stb_i && !stall_o;
         if (ack_o)
            acks++;
         if (accepted)
            sent++;
         if (!stb_i || accepted)
         begin
            if (sent >= n)
               stb_i <= 1'b0;
            else if (accepted && (($random(seed) & 3) == 0))
               stb_i <= 1'b0;  // idle gap.
            else
               put_xfer(sent);
         end
      end
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
      q_we.delete();
      q_adr.delete();
      q_sel.delete();
      q_dat.delete();
   endtask

   // mix sends later strobes to random regions.
   task automatic random_cycle(input tgt_t first, input int len, input logic mix);
      adr_t a;
      for (int i = 0; i < len; i++)
      begin
         a = $random(seed);
         a[BASE+1:BASE] = (i == 0 || !mix) ? first : tgt_t'($random(seed));
         a[1:0] = 2'b00;
         push_xfer(1'($random(seed)), a, sel_t'($random(seed)), $random(seed));
      end
      run_cycle();
   endtask

   task automatic fill_ram(input tgt_t t);
      adr_t a;
      for (int w = 0; w < RAM_WORDS; w++)
      begin
         a = '0;
         a[BASE+1:BASE] = t;
         a[RAM_AW+1:2] = w[RAM_AW-1:0];
         push_xfer(1'b1, a, 4'hf, a * 32'h9e37_79b1);
      end
      run_cycle();
   endtask

   always @(posedge clk_i)
   begin
      dat_t e;
      logic e_stall;
      if (!rst_i)
      begin
         e_stall = (m_wait1 != 0);
         assert (stall_o === e_stall)
         else
         begin
            $display("mismatch stall_o: expected %h, got %h", e_stall, stall_o);
            err_data++;
         end
         assert (cyc_i || !cyc_q || exp_q.size() == 0)
         else
         begin
            $display("cyc_i dropped with %0d acks still pending", exp_q.size());
            err_proto++;
         end
         if (ack_o)
         begin
            assert (exp_q.size() != 0)
            else
            begin
               $display("ack_o arrived with no transfer outstanding");
               err_proto++;
            end
            if (exp_q.size() != 0)
            begin
               e = exp_q.pop_front();
               assert (dat_o === e)
               else
               begin
                  $display("mismatch dat_o: expected %h, got %h", e, dat_o);
                  err_data++;
               end
            end
         end
         if (!cyc_i)
            locked = 1'b0;
         else if (!locked)
         begin
            locked = 1'b1;
            lk_tgt = adr_i[BASE+1:BASE];  // first address picks the target.
         end
         if (m_wait1 != 0)
            m_wait1--;
         if (cyc_i && stb_i && !stall_o)
         begin
            if (lk_tgt == TGT_RAM1)
               m_wait1 = RAM1_WAIT;  // stall for the wait states.
            exp_q.push_back(model_access(lk_tgt, we_i, adr_i, sel_i, dat_i));
         end
         cyc_q = cyc_i;
      end
   end

   initial
   begin
      seed  = 44;
      rst_i = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      sel_i = '0;
      dat_i = '0;
      repeat (5) @(posedge clk_i);
      rst_i <= 1'b0;
      fill_ram(TGT_RAM0);
      fill_ram(TGT_RAM1);
      repeat (N_SINGLE) random_cycle(tgt_t'($random(seed) & 1), 1, 1'b0);
      repeat (N_BURST) random_cycle(TGT_RAM0, burst_len(), 1'b0);
      repeat (N_BURST) random_cycle(TGT_RAM1, burst_len(), 1'b0);
      repeat (N_BURST) random_cycle(TGT_REGS, burst_len(), 1'b0);
      repeat (N_BURST) random_cycle(TGT_NONE, burst_len(), 1'b0);
      repeat (N_BURST) random_cycle(tgt_t'($random(seed)), burst_len(), 1'b1);
      // mapped targets again, after the stray traffic.
      repeat (N_SINGLE) random_cycle(tgt_t'($unsigned($random(seed)) % 3), 1, 1'b0);
      repeat (2) @(posedge clk_i);
      $display("errors: %0d data, %0d protocol", err_data, err_proto);
      if (err_data + err_proto == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   initial
   begin
      #(WD_TIME);
      $display("timeout: bus traffic did not finish within %0d ns", WD_TIME);
      $display("errors: %0d data, %0d protocol", err_data, err_proto);
      $display("Errors found");
      $finish;
   end

endmodule

/* list.f */
source/wb_pkg.sv
source/map_pkg.sv
source/if_wb.sv
source/wb_decoder.sv
source/wb_ram.sv
source/wb_regs.sv
source/wb_fabric.sv
verification/tb_fabric.sv

/* Makefile */
TOP = tb_fabric

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: help test clean
